//--- logic/ipu_pkg.sv
// Shared types and instruction patterns for the IPU; imported by every IPU module
`default_nettype none

package ipu_pkg;

  localparam int unsigned IdWidth = 5;  // Default transaction id width
  localparam int unsigned NumOps  = 23;

  // Order matches OpPatterns below
  typedef enum logic [4:0] {
    OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU,
    OP_DIV, OP_DIVU, OP_REM, OP_REMU,
    OP_ABS, OP_SLET, OP_SLETU, OP_MIN, OP_MINU, OP_MAX, OP_MAXU,
    OP_EXTHS, OP_EXTHZ, OP_EXTBS, OP_EXTBZ,
    OP_CLIP, OP_CLIPU, OP_CLIPR, OP_CLIPUR,
    OP_ILLEGAL
  } ipu_op_e;

  typedef enum logic [1:0] {
    UNIT_MUL  = 2'd0,
    UNIT_DIV  = 2'd1,
    UNIT_DSP  = 2'd2,
    UNIT_NONE = 2'd3
  } ipu_unit_e;

  typedef struct packed {
    logic [31:0] match;
    logic [31:0] mask;
  } ipu_pattern_t;

  // ----------------------------------------------------------------------
  // Instruction encodings, RV32M and Xpulpimg
  // ----------------------------------------------------------------------
  localparam logic [31:0] MaskR  = 32'hFE00_707F;  // funct7, funct3, opcode
  localparam logic [31:0] MaskR1 = 32'hFFF0_707F;  // Same plus rs2 field

  localparam ipu_pattern_t OpPatterns [NumOps] = '{
    '{32'h0200_0033, MaskR},  '{32'h0200_1033, MaskR},   // mul, mulh
    '{32'h0200_2033, MaskR},  '{32'h0200_3033, MaskR},   // mulhsu, mulhu
    '{32'h0200_4033, MaskR},  '{32'h0200_5033, MaskR},   // div, divu
    '{32'h0200_6033, MaskR},  '{32'h0200_7033, MaskR},   // rem, remu
    '{32'h0A00_0033, MaskR1}, '{32'h0A00_2033, MaskR},   // p.abs, p.slet
    '{32'h0A00_3033, MaskR},  '{32'h0A00_4033, MaskR},   // p.sletu, p.min
    '{32'h0A00_5033, MaskR},  '{32'h0A00_6033, MaskR},   // p.minu, p.max
    '{32'h0A00_7033, MaskR},  '{32'h1000_4033, MaskR1},  // p.maxu, p.exths
    '{32'h1000_5033, MaskR1}, '{32'h1000_6033, MaskR1},  // p.exthz, p.extbs
    '{32'h1000_7033, MaskR1}, '{32'h1400_1033, MaskR},   // p.extbz, p.clip
    '{32'h1400_2033, MaskR},  '{32'h1400_5033, MaskR},   // p.clipu, p.clipr
    '{32'h1400_6033, MaskR}                              // p.clipur
  };

  // ----------------------------------------------------------------------
  // Request and result buses
  // ----------------------------------------------------------------------
  typedef struct packed {
    ipu_op_e            op;
    logic [IdWidth-1:0] id;
    logic [31:0]        a;
    logic [31:0]        b;
    logic [4:0]         imm;  // Clip bound, instr[24:20]
  } ipu_req_t;

  typedef struct packed {
    logic [31:0]        result;
    logic [IdWidth-1:0] id;
  } ipu_res_t;

endpackage

`default_nettype wire

//--- logic/ipu_decoder.sv
// Instruction decoder of the IPU; steers each offloaded request to one execution unit
`timescale 1ns/100ps
`default_nettype none

module ipu_decoder import ipu_pkg::*; (
  input  logic [31:0]        instr_i,
  input  logic [IdWidth-1:0] id_i,
  input  logic [31:0]        arga_i,
  input  logic [31:0]        argb_i,
  input  logic               qvalid_i,
  input  logic               mul_ready_i,
  input  logic               div_ready_i,
  input  logic               dsp_ready_i,
  output ipu_req_t           req_o,
  output logic               mul_valid_o,
  output logic               div_valid_o,
  output logic               dsp_valid_o,
  output logic               qready_o
);

  ipu_op_e   op;
  ipu_unit_e unit;

  // Patterns are disjoint, at most one hits
  always_comb begin
    op = OP_ILLEGAL;
    for (int i = 0; i < NumOps; i++) begin
      if ((instr_i & OpPatterns[i].mask) == OpPatterns[i].match) begin
        op = ipu_op_e'(i);
      end
    end
  end

  always_comb begin
    if (op <= OP_MULHU) begin
      unit = UNIT_MUL;
    end else if (op <= OP_REMU) begin
      unit = UNIT_DIV;
    end else if (op != OP_ILLEGAL) begin
      unit = UNIT_DSP;
    end else begin
      unit = UNIT_NONE;
    end
  end

  always_comb begin
    mul_valid_o = 1'b0;
    div_valid_o = 1'b0;
    dsp_valid_o = 1'b0;
    qready_o    = 1'b0;  // Illegal words are never accepted
    unique case (unit)
      UNIT_MUL: begin
        mul_valid_o = qvalid_i;
        qready_o    = mul_ready_i;
      end
      UNIT_DIV: begin
        div_valid_o = qvalid_i;
        qready_o    = div_ready_i;
      end
      UNIT_DSP: begin
        dsp_valid_o = qvalid_i;
        qready_o    = dsp_ready_i;
      end
      default: qready_o = 1'b0;
    endcase
  end

  assign req_o.op  = op;
  assign req_o.id  = id_i;
  assign req_o.a   = arga_i;
  assign req_o.b   = argb_i;
  assign req_o.imm = instr_i[24:20];

endmodule

`default_nettype wire

//--- logic/ipu_multiplier.sv
// Two-stage pipelined 32x32 multiplier of the IPU for the RV32M multiply operations
`timescale 1ns/100ps
`default_nettype none

module ipu_multiplier import ipu_pkg::*; #(
  parameter int unsigned IdWidth = 5
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  ipu_req_t req_i,
  input  logic     valid_i,
  output logic     ready_o,
  output ipu_res_t res_o,
  output logic     valid_o,
  input  logic     ready_i
);

  logic               s1_valid_q, s2_valid_q;
  logic               advance;
  logic [32:0]        s1_a_q, s1_b_q;  // Sign or zero extended
  ipu_op_e            s1_op_q, s2_op_q;
  logic [IdWidth-1:0] s1_id_q, s2_id_q;
  logic signed [65:0] prod_full;
  logic [63:0]        s2_prod_q;
  logic               a_signed, b_signed;

  // Whole pipe moves when the head is empty or leaving
  assign advance = !s2_valid_q || ready_i;
  assign ready_o = advance;

  assign a_signed = (req_i.op == OP_MULH) || (req_i.op == OP_MULHSU);
  assign b_signed = (req_i.op == OP_MULH);

  // ----------------------------------------------------------------------
  // Stage valids
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      s1_valid_q <= 1'b0;
      s2_valid_q <= 1'b0;
    end else if (advance) begin
      s1_valid_q <= valid_i;
      s2_valid_q <= s1_valid_q;
    end
  end

  // Stage 1 operands
  always_ff @(posedge clk_i) begin
    if (advance && valid_i) begin
      s1_a_q  <= {a_signed & req_i.a[31], req_i.a};
      s1_b_q  <= {b_signed & req_i.b[31], req_i.b};
      s1_op_q <= req_i.op;
      s1_id_q <= req_i.id;
    end
  end

  assign prod_full = $signed(s1_a_q) * $signed(s1_b_q);

  // Stage 2 product
  always_ff @(posedge clk_i) begin
    if (advance && s1_valid_q) begin
      s2_prod_q <= prod_full[63:0];
      s2_op_q   <= s1_op_q;
      s2_id_q   <= s1_id_q;
    end
  end

  assign valid_o      = s2_valid_q;
  assign res_o.id     = s2_id_q;
  assign res_o.result = (s2_op_q == OP_MUL) ? s2_prod_q[31:0] : s2_prod_q[63:32];

endmodule

`default_nettype wire

//--- logic/ipu_serdiv.sv
// Serial restoring divider of the IPU for the RV32M divide and remainder operations
`timescale 1ns/100ps
`default_nettype none

module ipu_serdiv import ipu_pkg::*; #(
  parameter int unsigned IdWidth = 5
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  ipu_req_t req_i,
  input  logic     valid_i,
  output logic     ready_o,
  output ipu_res_t res_o,
  output logic     valid_o,
  input  logic     ready_i
);

  typedef enum logic [1:0] {
    IDLE,
    DIVIDE,
    FINISH
  } div_state_e;

  div_state_e         state_q;
  logic [4:0]         step_q;
  logic               accept;
  logic               op_signed, a_neg, b_neg;
  logic [31:0]        a_abs, b_abs;
  logic [31:0]        divisor_q, rem_q, quo_q;
  logic               neg_quo_q, neg_rem_q, is_rem_q;
  logic [IdWidth-1:0] id_q;
  logic [32:0]        trial;
  logic [31:0]        quo_fix, rem_fix;

  assign accept  = (state_q == IDLE) && valid_i;
  assign ready_o = (state_q == IDLE);
  assign valid_o = (state_q == FINISH);

  assign op_signed = (req_i.op == OP_DIV) || (req_i.op == OP_REM);
  assign a_neg     = op_signed & req_i.a[31];
  assign b_neg     = op_signed & req_i.b[31];
  assign a_abs     = a_neg ? -req_i.a : req_i.a;  // Min value stays 2^31 as unsigned
  assign b_abs     = b_neg ? -req_i.b : req_i.b;

  // ----------------------------------------------------------------------
  // Control FSM
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      step_q  <= '0;
    end else begin
      unique case (state_q)
        IDLE: begin
          if (accept) begin
            state_q <= DIVIDE;
            step_q  <= '0;
          end
        end
        DIVIDE: begin
          step_q <= step_q + 5'd1;
          if (step_q == 5'd31) begin
            state_q <= FINISH;
          end
        end
        FINISH: begin
          if (ready_i) begin
            state_q <= IDLE;  // Result held until taken
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Shift in next dividend bit and try to subtract
  assign trial = {rem_q, quo_q[31]} - {1'b0, divisor_q};

  always_ff @(posedge clk_i) begin
    if (accept) begin
      divisor_q <= b_abs;
      quo_q     <= a_abs;  // Dividend shifts out as quotient shifts in
      rem_q     <= '0;
      id_q      <= req_i.id;
      is_rem_q  <= (req_i.op == OP_REM) || (req_i.op == OP_REMU);
      neg_quo_q <= (a_neg ^ b_neg) && (req_i.b != '0);  // x/0 stays all ones
      neg_rem_q <= a_neg;
    end else if (state_q == DIVIDE) begin
      quo_q <= {quo_q[30:0], ~trial[32]};
      if (!trial[32]) begin
        rem_q <= trial[31:0];
      end else begin
        rem_q <= {rem_q[30:0], quo_q[31]};
      end
    end
  end

  // Overflow case comes out right: -(2^31) wraps back to the dividend
  assign quo_fix = neg_quo_q ? -quo_q : quo_q;
  assign rem_fix = neg_rem_q ? -rem_q : rem_q;

  assign res_o.result = is_rem_q ? rem_fix : quo_fix;
  assign res_o.id     = id_q;

endmodule

`default_nettype wire

//--- logic/ipu_dspu.sv
// Combinational Xpulpimg DSP unit of the IPU: abs, compare, min/max, extend and clip
`timescale 1ns/100ps
`default_nettype none

module ipu_dspu import ipu_pkg::*; #(
  parameter int unsigned IdWidth = 5
) (
  input  ipu_req_t req_i,
  input  logic     valid_i,
  output logic     ready_o,
  output ipu_res_t res_o,
  output logic     valid_o,
  input  logic     ready_i
);

  logic [31:0] a, b;
  logic [32:0] clip_mask;
  logic [31:0] clip_lo, clip_hi;  // Immediate bounds
  logic [31:0] reg_lo, reg_hi;    // Register bounds
  logic        lte_s, lte_u;

  // No state, handshake passes straight through
  assign valid_o = valid_i;
  assign ready_o = ready_i;

  assign a = req_i.a;
  assign b = req_i.b;

  // ----------------------------------------------------------------------
  // Clip bounds
  // ----------------------------------------------------------------------
  assign clip_mask = {33{1'b1}} << req_i.imm;
  assign clip_lo   = clip_mask[32:1];  // -2^(n-1), -1 for n = 0
  assign clip_hi   = ~clip_lo;         // 2^(n-1) - 1
  assign reg_hi    = b;
  assign reg_lo    = ~b;               // -b - 1

  assign lte_s = $signed(a) <= $signed(b);
  assign lte_u = a <= b;

  // ----------------------------------------------------------------------
  // Operation select
  // ----------------------------------------------------------------------
  always_comb begin
    res_o.id     = req_i.id[IdWidth-1:0];
    res_o.result = '0;
    unique case (req_i.op)
      OP_ABS:   res_o.result = a[31] ? -a : a;
      OP_SLET:  res_o.result = {31'b0, lte_s};
      OP_SLETU: res_o.result = {31'b0, lte_u};
      OP_MIN:   res_o.result = lte_s ? a : b;
      OP_MINU:  res_o.result = lte_u ? a : b;
      OP_MAX:   res_o.result = lte_s ? b : a;
      OP_MAXU:  res_o.result = lte_u ? b : a;
      OP_EXTHS: res_o.result = {{16{a[15]}}, a[15:0]};
      OP_EXTHZ: res_o.result = {16'b0, a[15:0]};
      OP_EXTBS: res_o.result = {{24{a[7]}}, a[7:0]};
      OP_EXTBZ: res_o.result = {24'b0, a[7:0]};
      OP_CLIP: begin
        if ($signed(a) <= $signed(clip_lo)) begin
          res_o.result = clip_lo;
        end else if ($signed(a) >= $signed(clip_hi)) begin
          res_o.result = clip_hi;
        end else begin
          res_o.result = a;
        end
      end
      OP_CLIPU: begin
        if ($signed(a) <= 0) begin
          res_o.result = '0;
        end else if ($signed(a) >= $signed(clip_hi)) begin
          res_o.result = clip_hi;
        end else begin
          res_o.result = a;
        end
      end
      OP_CLIPR: begin
        if ($signed(a) <= $signed(reg_lo)) begin
          res_o.result = reg_lo;
        end else if ($signed(a) >= $signed(reg_hi)) begin
          res_o.result = reg_hi;
        end else begin
          res_o.result = a;
        end
      end
      OP_CLIPUR: begin
        if ($signed(a) <= 0) begin
          res_o.result = '0;
        end else if ($signed(a) >= $signed(reg_hi)) begin
          res_o.result = reg_hi;
        end else begin
          res_o.result = a;
        end
      end
      default: res_o.result = '0;  // Other units' ops
    endcase
  end

endmodule

`default_nettype wire

//--- logic/ipu_result_arbiter.sv
// Round-robin arbiter of the IPU merging the three unit result streams onto the response port
`timescale 1ns/100ps
`default_nettype none

module ipu_result_arbiter import ipu_pkg::*; (
  input  logic           clk_i,
  input  logic           rst_n_i,
  input  ipu_res_t [2:0] res_i,
  input  logic [2:0]     valid_i,
  output logic [2:0]     ready_o,
  output ipu_res_t       res_o,
  output logic           ovalid_o,
  input  logic           oready_i
);

  logic [1:0] ptr_q;   // Highest priority input
  logic       lock_q;  // Output stalled, grant frozen
  logic [1:0] gnt_q;
  logic [1:0] cand, grant, idx;
  logic [2:0] sum;
  logic       found;

  // First valid input at or after the pointer
  always_comb begin
    cand  = ptr_q;
    found = 1'b0;
    for (int i = 0; i < 3; i++) begin
      sum = {1'b0, ptr_q} + 3'(i);
      idx = (sum >= 3'd3) ? 2'(sum - 3'd3) : sum[1:0];
      if (!found && valid_i[idx]) begin
        cand  = idx;
        found = 1'b1;
      end
    end
  end

  assign grant    = lock_q ? gnt_q : cand;
  assign ovalid_o = valid_i[grant];
  assign res_o    = res_i[grant];

  always_comb begin
    ready_o        = '0;
    ready_o[grant] = oready_i;
  end

  // ----------------------------------------------------------------------
  // Pointer and lock
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ptr_q  <= 2'(UNIT_MUL);
      lock_q <= 1'b0;
      gnt_q  <= 2'(UNIT_MUL);
    end else begin
      lock_q <= ovalid_o && !oready_i;
      gnt_q  <= grant;
      if (ovalid_o && oready_i) begin
        ptr_q <= (grant == 2'd2) ? 2'd0 : grant + 2'd1;  // Pass priority on
      end
    end
  end

endmodule

`default_nettype wire

//--- logic/ipu_top.sv
// Top level of the IPU accelerator; connects decoder, execution units and result arbiter
`timescale 1ns/100ps
`default_nettype none

module ipu_top import ipu_pkg::*; #(
  parameter int unsigned IdWidth = 5  // Must match the package default
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  // Request side
  input  logic [IdWidth-1:0] acc_qid_i,
  input  logic [31:0]        acc_qdata_op_i,  // Offloaded instruction word
  input  logic [31:0]        acc_qdata_arga_i,
  input  logic [31:0]        acc_qdata_argb_i,
  input  logic               acc_qvalid_i,
  output logic               acc_qready_o,
  // Response side
  output logic [31:0]        acc_pdata_o,
  output logic [IdWidth-1:0] acc_pid_o,
  output logic               acc_pvalid_o,
  input  logic               acc_pready_i
);

  ipu_req_t       req;
  logic           mul_in_valid, div_in_valid, dsp_in_valid;
  logic           mul_in_ready, div_in_ready, dsp_in_ready;
  ipu_res_t [2:0] unit_res;    // Indexed by ipu_unit_e
  logic [2:0]     unit_valid;
  logic [2:0]     unit_ready;
  ipu_res_t       arb_res;

  ipu_decoder u_decoder (
    .instr_i     (acc_qdata_op_i),
    .id_i        (acc_qid_i),
    .arga_i      (acc_qdata_arga_i),
    .argb_i      (acc_qdata_argb_i),
    .qvalid_i    (acc_qvalid_i),
    .mul_ready_i (mul_in_ready),
    .div_ready_i (div_in_ready),
    .dsp_ready_i (dsp_in_ready),
    .req_o       (req),
    .mul_valid_o (mul_in_valid),
    .div_valid_o (div_in_valid),
    .dsp_valid_o (dsp_in_valid),
    .qready_o    (acc_qready_o)
  );

  // ----------------------------------------------------------------------
  // Execution units
  // ----------------------------------------------------------------------
  ipu_multiplier #(
    .IdWidth (IdWidth)
  ) u_multiplier (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (req),
    .valid_i (mul_in_valid),
    .ready_o (mul_in_ready),
    .res_o   (unit_res[UNIT_MUL]),
    .valid_o (unit_valid[UNIT_MUL]),
    .ready_i (unit_ready[UNIT_MUL])
  );

  ipu_serdiv #(
    .IdWidth (IdWidth)
  ) u_serdiv (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .req_i   (req),
    .valid_i (div_in_valid),
    .ready_o (div_in_ready),
    .res_o   (unit_res[UNIT_DIV]),
    .valid_o (unit_valid[UNIT_DIV]),
    .ready_i (unit_ready[UNIT_DIV])
  );

  ipu_dspu #(
    .IdWidth (IdWidth)
  ) u_dspu (
    .req_i   (req),
    .valid_i (dsp_in_valid),
    .ready_o (dsp_in_ready),
    .res_o   (unit_res[UNIT_DSP]),
    .valid_o (unit_valid[UNIT_DSP]),
    .ready_i (unit_ready[UNIT_DSP])
  );

  ipu_result_arbiter u_result_arbiter (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .res_i    (unit_res),
    .valid_i  (unit_valid),
    .ready_o  (unit_ready),
    .res_o    (arb_res),
    .ovalid_o (acc_pvalid_o),
    .oready_i (acc_pready_i)
  );

  assign acc_pdata_o = arb_res.result;
  assign acc_pid_o   = arb_res.id;

endmodule

`default_nettype wire

//--- dv/ipu_clkgen.sv
// Clock and reset source for the IPU testbench; instantiated once by the testbench top
`timescale 1ns/100ps
`default_nettype none

module ipu_clkgen #(
  parameter int unsigned Period      = 8,  // ns
  parameter int unsigned ResetCycles = 2
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(Period / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    #1;
    rst_n_o = 1'b1;  // Released just after an edge
  end

endmodule

`default_nettype wire

//--- dv/ipu_checker.sv
// Response checker of the IPU testbench; matches each response transfer to its expected value by id
`timescale 1ns/100ps
`default_nettype none

module ipu_checker #(
  parameter int unsigned IdWidth = 5
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic [31:0]        pdata_i,
  input  logic [IdWidth-1:0] pid_i,
  input  logic               pvalid_i,
  input  logic               pready_i
);

  localparam int unsigned NumIds = 2 ** IdWidth;

  logic        pending  [NumIds];  // Response still owed for this id
  logic [31:0] expected [NumIds];
  int          mismatch_count;
  int          unexpected_count;
  int          missing_count;

  initial begin
    for (int i = 0; i < NumIds; i++) begin
      pending[i] = 1'b0;
    end
    mismatch_count   = 0;
    unexpected_count = 0;
    missing_count    = 0;
  end

  function automatic bit is_pending(input logic [IdWidth-1:0] id);
    return pending[id];
  endfunction

  function automatic int outstanding();
    int n;
    n = 0;
    for (int i = 0; i < NumIds; i++) begin
      if (pending[i]) begin
        n++;
      end
    end
    return n;
  endfunction

  task automatic expect_result(input logic [IdWidth-1:0] id, input logic [31:0] value);
    expected[id] = value;
    pending[id]  = 1'b1;
  endtask

  // ----------------------------------------------------------------------
  // Compare on every response transfer
  // ----------------------------------------------------------------------
  always @(posedge clk_i) begin
    if (rst_n_i && pvalid_i && pready_i) begin
      if (!pending[pid_i]) begin
        $display("Unexpected response with id %0d at %0t ns", pid_i, $time);
        unexpected_count++;
      end else begin
        if (pdata_i !== expected[pid_i]) begin
          $display("ERR %0t ns acc_pdata_o id %0d got %08h expected %08h",
                   $time, pid_i, pdata_i, expected[pid_i]);
          mismatch_count++;
        end
        pending[pid_i] = 1'b0;
      end
    end
  end

  task automatic wait_drained(input int unsigned max_cycles, output bit drained);
    int unsigned cycles;
    cycles = 0;
    while (outstanding() != 0 && cycles < max_cycles) begin
      @(posedge clk_i);
      #1;
      cycles++;
    end
    drained = (outstanding() == 0);
    if (!drained) begin
      $display("Timeout waiting for the outstanding responses");
      for (int i = 0; i < NumIds; i++) begin
        if (pending[i]) begin
          $display("No response arrived for id %0d", i);
          missing_count++;
        end
      end
    end
  endtask

endmodule

`default_nettype wire

//--- dv/ipu_tb.sv
// Testbench top of the IPU; reads the stimulus file and drives requests with back-pressure
`timescale 1ns/100ps
`default_nettype none

module ipu_tb import ipu_pkg::*; ();

  localparam int unsigned NumIds        = 2 ** IdWidth;
  localparam int unsigned QreadyTimeout = 100;
  localparam int unsigned SlotTimeout   = 200;
  localparam int unsigned DrainTimeout  = 500;
  localparam int unsigned ResetTimeout  = 20;
  localparam int unsigned IllegalHold   = 10;

  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] expected;
    logic        legal;
  } vector_t;

  logic               clk, rst_n;
  logic [IdWidth-1:0] qid, pid;
  logic [31:0]        qinstr, qarga, qargb, pdata;
  logic               qvalid, qready, pvalid, pready;

  vector_t     vectors[$];
  int          timeout_errs, illegal_errs, other_errs;

  ipu_clkgen #(.Period(8), .ResetCycles(2)) u_clkgen (.clk_o(clk), .rst_n_o(rst_n));

  ipu_top #(
    .IdWidth (IdWidth)
  ) DUT (
    .clk_i            (clk),
    .rst_n_i          (rst_n),
    .acc_qid_i        (qid),
    .acc_qdata_op_i   (qinstr),
    .acc_qdata_arga_i (qarga),
    .acc_qdata_argb_i (qargb),
    .acc_qvalid_i     (qvalid),
    .acc_qready_o     (qready),
    .acc_pdata_o      (pdata),
    .acc_pid_o        (pid),
    .acc_pvalid_o     (pvalid),
    .acc_pready_i     (pready)
  );

  ipu_checker #(
    .IdWidth (IdWidth)
  ) u_checker (
    .clk_i    (clk),
    .rst_n_i  (rst_n),
    .pdata_i  (pdata),
    .pid_i    (pid),
    .pvalid_i (pvalid),
    .pready_i (pready)
  );

  // Random back-pressure with ready three cycles in four
  initial begin
    void'($urandom(32'ha291));
    pready = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      pready = ($urandom % 4) != 0;
    end
  end

  // ----------------------------------------------------------------------
  // Stimulus tasks
  // ----------------------------------------------------------------------
  task automatic read_vectors();
    int          fd;
    int          n;
    string       line;
    logic [31:0] instr, a, b, expected, legal;
    vector_t     v;
    fd = $fopen("dv/ipu_input.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file dv/ipu_input.txt");
      other_errs++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 0) begin
        n = $sscanf(line, "%h %h %h %h %h", instr, a, b, expected, legal);
        if (n == 5) begin  // Comment and blank lines fall out here
          v.instr    = instr;
          v.a        = a;
          v.b        = b;
          v.expected = expected;
          v.legal    = legal[0];
          vectors.push_back(v);
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic wait_slot_free(input logic [IdWidth-1:0] id, output bit ok);
    int unsigned cycles;
    cycles = 0;
    while (u_checker.is_pending(id) && cycles < SlotTimeout) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    ok = !u_checker.is_pending(id);
  endtask

  task automatic issue_request(input vector_t v, input logic [IdWidth-1:0] id, output bit ok);
    int unsigned cycles;
    bit          accepted;
    qid      = id;
    qinstr   = v.instr;
    qarga    = v.a;
    qargb    = v.b;
    qvalid   = 1'b1;
    cycles   = 0;
    accepted = 1'b0;
    while (!accepted && cycles < QreadyTimeout) begin
      @(posedge clk);
      accepted = qready;  // Transfer on this edge
      cycles++;
    end
    #1;
    qvalid = 1'b0;
    ok     = accepted;
  endtask

  task automatic hold_illegal(input vector_t v, input logic [IdWidth-1:0] id);
    qid    = id;
    qinstr = v.instr;
    qarga  = v.a;
    qargb  = v.b;
    qvalid = 1'b1;
    for (int i = 0; i < IllegalHold; i++) begin
      @(posedge clk);
      if (qready !== 1'b0) begin
        $display("ERR %0t ns acc_qready_o id %0d got %b expected 0", $time, id, qready);
        illegal_errs++;
      end
    end
    #1;
    qvalid = 1'b0;
  endtask

  // ----------------------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------------------
  initial begin
    bit                 ok;
    int unsigned        rst_cycles;
    logic [IdWidth-1:0] id;
    int                 total;
    qid          = '0;
    qinstr       = '0;
    qarga        = '0;
    qargb        = '0;
    qvalid       = 1'b0;
    timeout_errs = 0;
    illegal_errs = 0;
    other_errs   = 0;
    rst_cycles   = 0;
    while (rst_n !== 1'b1 && rst_cycles < ResetTimeout) begin
      @(posedge clk);
      rst_cycles++;
    end
    if (rst_n !== 1'b1) begin
      $display("Reset was never released");
      timeout_errs++;
    end
    @(posedge clk);
    #1;
    read_vectors();
    if (vectors.size() == 0) begin
      $display("No stimulus vectors were read");
      other_errs++;
    end
    for (int i = 0; i < vectors.size() && timeout_errs == 0; i++) begin
      id = IdWidth'(i % NumIds);
      wait_slot_free(id, ok);
      if (!ok) begin
        $display("Timeout waiting for id %0d to become free", id);
        timeout_errs++;
      end else if (vectors[i].legal) begin
        u_checker.expect_result(id, vectors[i].expected);
        issue_request(vectors[i], id, ok);
        if (!ok) begin
          $display("Timeout waiting for acc_qready_o on vector %0d", i);
          timeout_errs++;
        end
      end else begin
        hold_illegal(vectors[i], id);
      end
    end
    u_checker.wait_drained(DrainTimeout, ok);
    total = timeout_errs + illegal_errs + other_errs + u_checker.mismatch_count
          + u_checker.unexpected_count + u_checker.missing_count;
    $display(
      "Errors: %0d mismatch, %0d unexpected, %0d missing, %0d illegal, %0d timeout, %0d other",
      u_checker.mismatch_count, u_checker.unexpected_count, u_checker.missing_count,
      illegal_errs, timeout_errs, other_errs);
    if (total == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/ipu_input.txt
// Columns (hex): instruction word, operand a, operand b, expected result, legal flag
// Legal flag 0 marks a word the IPU must never accept
02B50533 00001234 00005678 06260060 1
02000033 FFFFFFFF 00000003 FFFFFFFD 1
02001033 80000000 80000000 40000000 1
02001033 FFFFFFFE 00000003 FFFFFFFF 1
02002033 FFFFFFFF FFFFFFFF FFFFFFFF 1
02002033 80000000 00000004 FFFFFFFE 1
02003033 FFFFFFFF FFFFFFFF FFFFFFFE 1
02003033 80000000 00000004 00000002 1
02004033 FFFFFFF9 00000002 FFFFFFFD 1
02006033 FFFFFFF9 00000002 FFFFFFFF 1
02004033 00000007 FFFFFFFE FFFFFFFD 1
02006033 00000007 FFFFFFFE 00000001 1
02005033 FFFFFFF9 00000002 7FFFFFFC 1
02007033 FFFFFFF9 00000002 00000001 1
02004033 00000055 00000000 FFFFFFFF 1
02006033 FFFFFFFB 00000000 FFFFFFFB 1
02005033 12345678 00000000 FFFFFFFF 1
02007033 12345678 00000000 12345678 1
02004033 80000000 FFFFFFFF 80000000 1
02006033 80000000 FFFFFFFF 00000000 1
00B50533 00000001 00000002 00000000 0
0A050533 FFFFFF85 00000000 0000007B 1
0A002033 FFFFFFFF 00000001 00000001 1
0A003033 FFFFFFFF 00000001 00000000 1
0A004033 FFFFFFF0 00000005 FFFFFFF0 1
0A005033 FFFFFFF0 00000005 00000005 1
0A006033 FFFFFFF0 00000005 00000005 1
0A007033 FFFFFFF0 00000005 FFFFFFF0 1
10004033 12348001 00000000 FFFF8001 1
10005033 12348001 00000000 00008001 1
10006033 123456F0 00000000 FFFFFFF0 1
10007033 123456F0 00000000 000000F0 1
14001033 00000064 00000000 00000000 1
14001033 FFFFFFCE 00000000 FFFFFFFF 1
14101033 FFFFFF00 00000000 FFFFFFFF 1
15F01033 7FFFFFFF 00000000 3FFFFFFF 1
15F01033 80000000 00000000 C0000000 1
14801033 00000050 00000000 00000050 1
14802033 FFFFFFFB 00000000 00000000 1
14802033 0000012C 00000000 0000007F 1
14005033 FFFFFF00 00000010 FFFFFFEF 1
14005033 00000064 00000010 00000010 1
14005033 00000005 FFFFFFF0 0000000F 1
14006033 00000400 000000FF 000000FF 1
14006033 FFFFFFFD 000000FF 00000000 1
0A100033 00000003 00000000 00000000 0

//--- compile.f
logic/ipu_pkg.sv
logic/ipu_decoder.sv
logic/ipu_multiplier.sv
logic/ipu_serdiv.sv
logic/ipu_dspu.sv
logic/ipu_result_arbiter.sv
logic/ipu_top.sv
dv/ipu_clkgen.sv
dv/ipu_checker.sv
dv/ipu_tb.sv
